/* Makefile */
VERILATOR ?= verilator
TOP ?= pipe_core_tb
RTL_TOP ?= pipe_core
FLIST ?= pipe_core.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing
PASS_TEXT ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

/* dv/pipe_core_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_core_checker (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic hold,
    input  wire logic wb_valid,
    input  wire logic [pipe_pkg::REG_AW-1:0] wb_addr,
    input  wire logic [pipe_pkg::XLEN-1:0] wb_data,
    input  wire logic exp_valid,
    input  wire logic [pipe_pkg::REG_AW-1:0] exp_addr,
    input  wire logic [pipe_pkg::XLEN-1:0] exp_data,
    input  wire logic [5:0] exp_hold,
    input  wire logic end_run,
    output int mismatch_count,
    output int error_count,
    output int pending,
    output logic closed
);
    import pipe_pkg::*;

    logic [REG_AW+XLEN-1:0] exp_q [$];   // Address and data in issue order.
    int hold_q [$];   // Hold cycles expected ahead of each write-back.
    logic [REG_AW+XLEN-1:0] head;
    int hold_exp;
    int hold_run;

    initial begin
        mismatch_count = 0;
        error_count = 0;
        pending = 0;
        closed = 1'b0;
        hold_run = 0;
    end

    // Registered DUT outputs are read before this edge updates them.
    always @(posedge clk) begin
        if (rst) begin
            if (hold || wb_valid) begin
                $display("error at %0t: hold or wb_valid is high during reset", $time);
                error_count++;
            end
        end else begin
            if (wb_valid) begin
                if (exp_q.size() == 0) begin
                    $display("error at %0t: write-back to r%0d with nothing expected",
                             $time, wb_addr);
                    error_count++;
                end else begin
                    head = exp_q.pop_front();
                    hold_exp = hold_q.pop_front();
                    if (head !== {wb_addr, wb_data}) begin
                        $display("mismatch at %0t: expected r%0d = %h, got r%0d = %h", $time,
                                 head[REG_AW+XLEN-1:XLEN], head[XLEN-1:0], wb_addr, wb_data);
                        mismatch_count++;
                    end
                    if (hold_run != hold_exp) begin
                        $display("mismatch at %0t: %0d hold cycles before r%0d, expected %0d",
                                 $time, hold_run, wb_addr, hold_exp);
                        mismatch_count++;
                    end
                end
                hold_run = 0;
            end
            if (hold) begin
                hold_run++;
            end
            if (exp_valid) begin
                exp_q.push_back({exp_addr, exp_data});   // Newest goes to the back.
                hold_q.push_back(int'(exp_hold));
            end
            if (end_run && !closed) begin
                if (exp_q.size() != 0) begin
                    $display("error: %0d expected write-backs never appeared", exp_q.size());
                    error_count++;
                end
                closed = 1'b1;
            end
        end
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

/* dv/pipe_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_core_tb;
    import pipe_pkg::*;

    localparam int RANDOM_COUNT = 200;
    localparam int CYCLES_PER_INSTR = 40;
    localparam int DRAIN_LIMIT = 100;

    logic clk;
    logic rst;
    logic instr_valid;
    logic [INSTR_W-1:0] instr;
    logic hold;
    logic wb_valid;
    logic [REG_AW-1:0] wb_addr;
    logic [XLEN-1:0] wb_data;
    logic exp_valid;
    logic [REG_AW-1:0] exp_addr;
    logic [XLEN-1:0] exp_data;
    logic [5:0] exp_hold;
    logic end_run;
    logic closed;
    int mismatch_count;
    int error_count;
    int pending;

    logic [INSTR_W-1:0] tbl_word [$];
    logic [XLEN-1:0] tbl_exp [$];
    logic [XLEN-1:0] model [NREGS];   // Architectural register state in program order.
    logic [31:0] rng_state;
    int cycles;
    int cycle_limit;

    pipe_core pipe_core_inst (
        .clk(clk),
        .rst(rst),
        .instr_valid(instr_valid),
        .instr(instr),
        .hold(hold),
        .wb_valid(wb_valid),
        .wb_addr(wb_addr),
        .wb_data(wb_data)
    );

    pipe_core_checker checker_inst (
        .clk(clk),
        .rst(rst),
        .hold(hold),
        .wb_valid(wb_valid),
        .wb_addr(wb_addr),
        .wb_data(wb_data),
        .exp_valid(exp_valid),
        .exp_addr(exp_addr),
        .exp_data(exp_data),
        .exp_hold(exp_hold),
        .end_run(end_run),
        .mismatch_count(mismatch_count),
        .error_count(error_count),
        .pending(pending),
        .closed(closed)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("errors: %0d mismatches, %0d other failures", mismatch_count, error_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [INSTR_W-1:0] encode(op_e op, int rd, int rs1, int rs2,
                                                  logic use_imm, int imm);
        logic [INSTR_W-1:0] w;
        w = '0;
        w[OPC_HI:OPC_LO] = op;
        w[RD_HI:RD_LO] = rd[REG_AW-1:0];
        w[RS1_HI:RS1_LO] = rs1[REG_AW-1:0];
        w[RS2_HI:RS2_LO] = rs2[REG_AW-1:0];
        w[USE_IMM_BIT] = use_imm;
        w[IMM_HI:IMM_LO] = imm[IMM_W-1:0];
        return w;
    endfunction

    function automatic logic [XLEN-1:0] model_alu(op_e op, logic [XLEN-1:0] a,
                                                  logic [XLEN-1:0] b);
        case (op)
            ADD: return a + b;
            SUB: return a - b;
            AND: return a & b;
            OR:  return a | b;
            XOR: return a ^ b;
            SLL: return a << b[4:0];
            SRL: return a >> b[4:0];
            SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            MUL: return a * b;   // Truncates to the low word.
            default: return '0;
        endcase
    endfunction

    // A MUL holds one cycle plus one per multiplier bit up to the highest set bit.
    function automatic int hold_cycles(input logic [INSTR_W-1:0] word);
        logic [IMM_W-1:0] imm;
        logic [XLEN-1:0] b;
        int n;
        imm = word[IMM_HI:IMM_LO];
        b = word[USE_IMM_BIT] ? {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm}
                              : model[word[RS2_HI:RS2_LO]];
        n = 1;
        for (int i = 0; i < XLEN; i++) begin
            if (b[i]) begin
                n = i + 2;
            end
        end
        return n;
    endfunction

    function automatic void reg_op(op_e op, int rd, int rs1, int rs2, logic [XLEN-1:0] value);
        tbl_word.push_back(encode(op, rd, rs1, rs2, 1'b0, 0));
        tbl_exp.push_back(value);
    endfunction

    function automatic void imm_op(op_e op, int rd, int rs1, int imm, logic [XLEN-1:0] value);
        tbl_word.push_back(encode(op, rd, rs1, 0, 1'b1, imm));
        tbl_exp.push_back(value);
    endfunction

    // Keeps the word on instr until an edge with hold low takes it.
    task automatic issue_instr(input logic [INSTR_W-1:0] word, input logic [XLEN-1:0] value);
        op_e op;
        logic [REG_AW-1:0] rd;
        logic [5:0] hold_len;
        logic taken;
        op = op_e'(word[OPC_HI:OPC_LO]);
        rd = word[RD_HI:RD_LO];
        hold_len = (op == MUL) ? 6'(hold_cycles(word)) : 6'd0;
        taken = 1'b0;
        instr_valid = 1'b1;
        instr = word;
        while (!taken) begin
            taken = !hold;
            exp_valid = taken && (op != NOP);
            exp_addr = rd;
            exp_data = value;
            exp_hold = hold_len;
            @(negedge clk);
        end
        exp_valid = 1'b0;
        instr_valid = 1'b0;
        if (op != NOP && rd != '0) model[rd] = value;
    endtask

    task automatic issue_random();
        logic [31:0] r;
        logic [4:0] opc;
        op_e op;
        int rd;
        int rs1;
        int rs2;
        logic [XLEN-1:0] b;
        rng_state = xorshift(rng_state);
        r = rng_state;
        opc = 5'(r % 32'd10);
        op = op_e'(opc);
        rd = int'(r[10:8]);   // Few registers make dependences frequent.
        rs1 = int'(r[13:11]);
        rs2 = int'(r[16:14]);
        b = r[17] ? {{(XLEN-IMM_W){r[28]}}, r[28:18]} : model[rs2];
        issue_instr(encode(op, rd, rs1, rs2, r[17], int'(r[28:18])),
                    model_alu(op, model[rs1], b));
    endtask

    task automatic load_table();
        reg_op(ADD, 1, 1, 2, 32'h0);
        imm_op(ADD, 1, 0, 5, 32'h5);
        imm_op(ADD, 2, 0, -3, 32'hffff_fffd);
        reg_op(ADD, 3, 1, 2, 32'h2);
        reg_op(SUB, 4, 1, 2, 32'h8);
        imm_op(AND, 5, 2, 'h0f0, 32'hf0);
        reg_op(OR, 6, 1, 2, 32'hffff_fffd);
        imm_op(XOR, 7, 2, -1, 32'h2);
        imm_op(SLL, 8, 1, 33, 32'ha);   // Only the low 5 bits shift.
        reg_op(SRL, 9, 2, 1, 32'h07ff_ffff);
        reg_op(SLT, 10, 2, 1, 32'h1);
        imm_op(SLT, 11, 1, -8, 32'h0);
        imm_op(ADD, 12, 0, 100, 32'h64);
        reg_op(ADD, 13, 12, 12, 32'hc8);
        reg_op(NOP, 1, 1, 1, 32'h0);
        reg_op(SUB, 14, 13, 12, 32'h64);
        reg_op(ADD, 14, 14, 14, 32'hc8);
        imm_op(ADD, 0, 1, 1, 32'h6);
        reg_op(ADD, 15, 0, 1, 32'h5);
        reg_op(MUL, 16, 1, 0, 32'h0);
        imm_op(MUL, 17, 1, 7, 32'h23);
        imm_op(ADD, 18, 17, 1, 32'h24);
        reg_op(MUL, 19, 2, 2, 32'h9);
        imm_op(MUL, 20, 19, -1024, 32'hffff_dc00);
        reg_op(SUB, 21, 20, 19, 32'hffff_dbf7);
        reg_op(ADD, 22, 1, 1, 32'ha);
        reg_op(ADD, 23, 20, 0, 32'hffff_dc00);
        imm_op(MUL, 24, 1, 1, 32'h5);
    endtask

    initial begin
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        exp_valid = 1'b0;
        exp_addr = '0;
        exp_data = '0;
        exp_hold = '0;
        end_run = 1'b0;
        cycles = 0;
        rng_state = 32'h1867f6a7;
        foreach (model[i]) model[i] = '0;
        load_table();
        cycle_limit = (tbl_word.size() + RANDOM_COUNT) * CYCLES_PER_INSTR + 100;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        foreach (tbl_word[i]) issue_instr(tbl_word[i], tbl_exp[i]);
        repeat (RANDOM_COUNT) issue_random();
        for (int k = 0; k < DRAIN_LIMIT && pending != 0; k++) @(negedge clk);
        end_run = 1'b1;
        while (!closed) @(negedge clk);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, error_count);
        if (mismatch_count + error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic instr_valid,
    input  wire logic [pipe_pkg::INSTR_W-1:0] instr,
    input  wire logic hold,
    input  wire logic wb_valid,
    input  wire logic [pipe_pkg::REG_AW-1:0] wb_addr,
    input  wire logic [pipe_pkg::XLEN-1:0] wb_data,
    issue_if.issue_src issue
);
    import pipe_pkg::*;

    logic [XLEN-1:0] regs [NREGS];
    logic [INSTR_W-1:0] instr_q;
    logic instr_valid_q;

    op_e f_op;
    logic [REG_AW-1:0] f_rd;
    logic [REG_AW-1:0] f_rs1;
    logic [REG_AW-1:0] f_rs2;
    logic [IMM_W-1:0] f_imm;
    logic [XLEN-1:0] rf_rs1;
    logic [XLEN-1:0] rf_rs2;

    assign f_op = op_e'(instr_q[OPC_HI:OPC_LO]);
    assign f_rd = instr_q[RD_HI:RD_LO];
    assign f_rs1 = instr_q[RS1_HI:RS1_LO];
    assign f_rs2 = instr_q[RS2_HI:RS2_LO];
    assign f_imm = instr_q[IMM_HI:IMM_LO];

    // A write in this same cycle is passed straight through to the read.
    assign rf_rs1 = (f_rs1 == '0) ? '0 :
                    (wb_valid && wb_addr == f_rs1) ? wb_data : regs[f_rs1];
    assign rf_rs2 = (f_rs2 == '0) ? '0 :
                    (wb_valid && wb_addr == f_rs2) ? wb_data : regs[f_rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;   // Entry 0 is never written.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instr_valid_q <= 1'b0;
            instr_q <= '0;
        end else if (!hold) begin
            instr_valid_q <= instr_valid;
            instr_q <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issue.valid <= 1'b0;
            issue.op <= NOP;
            issue.rd <= '0;
            issue.rs1 <= '0;
            issue.rs2 <= '0;
            issue.rs1_data <= '0;
            issue.rs2_data <= '0;
            issue.use_imm <= 1'b0;
            issue.imm_ext <= '0;
        end else if (!hold) begin
            issue.valid <= instr_valid_q && (f_op != NOP);
            issue.op <= f_op;
            issue.rd <= f_rd;
            issue.rs1 <= f_rs1;
            issue.rs2 <= f_rs2;
            issue.rs1_data <= rf_rs1;
            issue.rs2_data <= rf_rs2;
            issue.use_imm <= instr_q[USE_IMM_BIT];
            issue.imm_ext <= {{(XLEN-IMM_W){f_imm[IMM_W-1]}}, f_imm};
        end else begin
            // The result stage drains during a hold, so a write landing now
            // would no longer be visible to execute's forwarding later.
            if (wb_valid && wb_addr != '0 && wb_addr == issue.rs1) begin
                issue.rs1_data <= wb_data;
            end
            if (wb_valid && wb_addr != '0 && wb_addr == issue.rs2) begin
                issue.rs2_data <= wb_data;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/exec_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  wire logic clk,
    input  wire logic rst,
    issue_if.issue_dst issue,
    input  wire logic wb_valid,
    input  wire logic [pipe_pkg::REG_AW-1:0] wb_addr,
    input  wire logic [pipe_pkg::XLEN-1:0] wb_data,
    output logic hold,
    output logic res_valid,
    output logic [pipe_pkg::REG_AW-1:0] res_addr,
    output logic [pipe_pkg::XLEN-1:0] res_data
);
    import pipe_pkg::*;

    logic ex_valid;
    logic ex_mul;
    logic [REG_AW-1:0] ex_rd;
    logic [XLEN-1:0] alu_q;

    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] product;
    logic mul_done;
    logic is_mul;
    logic mul_start;

    // Newest value wins: own output register first, then the result stage.
    function automatic logic [XLEN-1:0] fwd(input logic [REG_AW-1:0] addr,
                                            input logic [XLEN-1:0] rf_data);
        logic [XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (ex_valid && ex_rd == addr) begin
            value = res_data;
        end else if (wb_valid && wb_addr == addr) begin
            value = wb_data;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    always_comb begin
        src1 = fwd(issue.rs1, issue.rs1_data);
        src2 = fwd(issue.rs2, issue.rs2_data);
    end

    assign op_b = issue.use_imm ? issue.imm_ext : src2;

    always_comb begin
        case (issue.op)
            ADD: alu_out = src1 + op_b;
            SUB: alu_out = src1 - op_b;
            AND: alu_out = src1 & op_b;
            OR:  alu_out = src1 | op_b;
            XOR: alu_out = src1 ^ op_b;
            SLL: alu_out = src1 << op_b[SHAMT_W-1:0];
            SRL: alu_out = src1 >> op_b[SHAMT_W-1:0];
            SLT: alu_out = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(op_b)};
            default: alu_out = '0;   // MUL result comes from the multiplier.
        endcase
    end

    assign is_mul = issue.valid && (issue.op == MUL);
    assign mul_start = is_mul && !hold;

    mul_unit mul_inst (
        .clk(clk),
        .rst(rst),
        .start(mul_start),
        .a(src1),
        .b(op_b),
        .product(product),
        .done(mul_done)
    );

    assign hold = ex_mul && !mul_done;
    assign res_valid = ex_valid && !hold;   // Bubble into the result stage while waiting.
    assign res_addr = ex_rd;
    assign res_data = ex_mul ? product : alu_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
            ex_mul <= 1'b0;
            ex_rd <= '0;
            alu_q <= '0;
        end else if (!hold) begin
            ex_valid <= issue.valid;
            ex_mul <= is_mul;
            ex_rd <= issue.rd;
            alu_q <= alu_out;
        end
    end

endmodule

`default_nettype wire

/* logic/issue_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface issue_if;
    import pipe_pkg::*;

    logic valid;
    op_e op;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [XLEN-1:0] rs1_data;   // Register file value, may be stale.
    logic [XLEN-1:0] rs2_data;
    logic use_imm;
    logic [XLEN-1:0] imm_ext;   // Already sign-extended.

    modport issue_src (
        output valid,
        output op,
        output rd,
        output rs1,
        output rs2,
        output rs1_data,
        output rs2_data,
        output use_imm,
        output imm_ext
    );

    // Execute resolves forwarding on top of these values.
    modport issue_dst (
        input valid,
        input op,
        input rd,
        input rs1,
        input rs2,
        input rs1_data,
        input rs2_data,
        input use_imm,
        input imm_ext
    );

endinterface

`default_nettype wire

/* logic/mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic start,
    input  wire logic [pipe_pkg::XLEN-1:0] a,
    input  wire logic [pipe_pkg::XLEN-1:0] b,
    output logic [pipe_pkg::XLEN-1:0] product,
    output logic done
);
    import pipe_pkg::*;

    logic [XLEN-1:0] mcand;
    logic [XLEN-1:0] mplier;
    logic [XLEN-1:0] acc;
    logic busy;

    assign product = acc;

    // One multiplier bit per cycle; stops once no set bits remain.
    always_ff @(posedge clk) begin
        if (rst) begin
            mcand <= '0;
            mplier <= '0;
            acc <= '0;
            busy <= 1'b0;
            done <= 1'b0;
        end else if (start) begin
            mcand <= a;
            mplier <= b;
            acc <= '0;
            busy <= 1'b1;
            done <= 1'b0;
        end else if (busy) begin
            if (mplier == '0) begin
                busy <= 1'b0;
                done <= 1'b1;   // Held until the next start.
            end else begin
                if (mplier[0]) begin
                    acc <= acc + mcand;
                end
                mcand <= mcand << 1;
                mplier <= mplier >> 1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/pipe_core.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_core (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic instr_valid,
    input  wire logic [pipe_pkg::INSTR_W-1:0] instr,
    output logic hold,
    output logic wb_valid,
    output logic [pipe_pkg::REG_AW-1:0] wb_addr,
    output logic [pipe_pkg::XLEN-1:0] wb_data
);
    import pipe_pkg::*;

    logic res_valid;
    logic [REG_AW-1:0] res_addr;
    logic [XLEN-1:0] res_data;

    issue_if issue_bus ();

    decode_stage decode_inst (
        .clk(clk),
        .rst(rst),
        .instr_valid(instr_valid),
        .instr(instr),
        .hold(hold),
        .wb_valid(wb_valid),
        .wb_addr(wb_addr),
        .wb_data(wb_data),
        .issue(issue_bus.issue_src)
    );

    exec_stage exec_inst (
        .clk(clk),
        .rst(rst),
        .issue(issue_bus.issue_dst),
        .wb_valid(wb_valid),
        .wb_addr(wb_addr),
        .wb_data(wb_data),
        .hold(hold),
        .res_valid(res_valid),
        .res_addr(res_addr),
        .res_data(res_data)
    );

    result_stage result_inst (
        .clk(clk),
        .rst(rst),
        .res_valid(res_valid),
        .res_addr(res_addr),
        .res_data(res_data),
        .wb_valid(wb_valid),
        .wb_addr(wb_addr),
        .wb_data(wb_data)
    );

endmodule

`default_nettype wire

/* logic/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    localparam int XLEN = 32;
    localparam int REG_AW = 5;
    localparam int NREGS = 2 ** REG_AW;
    localparam int IMM_W = 11;
    localparam int INSTR_W = 32;
    localparam int SHAMT_W = 5;   // Shift amount taken from operand b.

    // Instruction word layout.
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 27;
    localparam int RD_HI = 26;
    localparam int RD_LO = 22;
    localparam int RS1_HI = 21;
    localparam int RS1_LO = 17;
    localparam int RS2_HI = 16;
    localparam int RS2_LO = 12;
    localparam int USE_IMM_BIT = 11;
    localparam int IMM_HI = 10;
    localparam int IMM_LO = 0;

    typedef enum logic [4:0] {
        NOP = 5'd0,
        ADD = 5'd1,
        SUB = 5'd2,
        AND = 5'd3,
        OR  = 5'd4,
        XOR = 5'd5,
        SLL = 5'd6,
        SRL = 5'd7,
        SLT = 5'd8,   // Signed compare, result is 1 or 0.
        MUL = 5'd9    // Low half of the product.
    } op_e;

endpackage

`default_nettype wire

/* logic/result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic res_valid,
    input  wire logic [pipe_pkg::REG_AW-1:0] res_addr,
    input  wire logic [pipe_pkg::XLEN-1:0] res_data,
    output logic wb_valid,
    output logic [pipe_pkg::REG_AW-1:0] wb_addr,
    output logic [pipe_pkg::XLEN-1:0] wb_data
);
    import pipe_pkg::*;

    logic [REG_AW-1:0] addr_q;
    logic [XLEN-1:0] data_q;
    logic valid_q;

    // These outputs feed the register file write and the oldest forwarding
    // path alike, so both always agree on the value being retired.
    assign wb_valid = valid_q;
    assign wb_addr = addr_q;
    assign wb_data = data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            addr_q <= '0;
            data_q <= '0;
        end else begin
            valid_q <= res_valid;   // One pulse per completed instruction.
            if (res_valid) begin
                addr_q <= res_addr;
                data_q <= res_data;
            end
        end
    end

endmodule

`default_nettype wire

/* pipe_core.f */
logic/pipe_pkg.sv
logic/issue_if.sv
logic/mul_unit.sv
logic/decode_stage.sv
logic/exec_stage.sv
logic/result_stage.sv
logic/pipe_core.sv
dv/pipe_core_checker.sv
dv/pipe_core_tb.sv
